// File: source/image_pkg.sv
// block image shared definitions

package image_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int IMG_W        = 320;
    localparam int IMG_H        = 240;
    localparam int BLK_DIM      = 8;
    localparam int BLK_PIXELS   = BLK_DIM * BLK_DIM;
    localparam int BLKS_PER_ROW = IMG_W / BLK_DIM;  // 40
    localparam int FRAME_PIXELS = IMG_W * IMG_H;    // 76800
    localparam int ADDR_W       = $clog2(FRAME_PIXELS);
    localparam int HIST_BINS    = 256;
    localparam int COUNT_W      = 32;

    typedef logic [7:0]         pixel_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COUNT_W-1:0] count_t;

    // task op codes, anything else is ignored
    typedef enum logic [15:0] {
        OP_STREAM    = 16'hA010,
        OP_HISTOGRAM = 16'hA040
    } task_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic   valid;
        pixel_t data;
    } pix_in_t;

    typedef struct packed {
        logic   en;
        addr_t  addr;
        pixel_t data;
    } buf_wr_t;

    typedef struct packed {
        logic        start;
        logic [15:0] op;  // raw code, may be unknown
    } task_cmd_t;

    typedef struct packed {
        logic   valid;
        pixel_t data;
    } raster_out_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] bin;
        count_t     count;
    } hist_out_t;

endpackage

// File: source/histogram_table.sv
// grey level histogram counters

`timescale 1ns/1ps

module histogram_table (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               clear_i,
    input  logic               inc_i,
    input  image_pkg::pixel_t  inc_bin_i,
    input  image_pkg::pixel_t  rd_bin_i,
    output image_pkg::count_t  rd_count_o
);
    import image_pkg::*;

    count_t bin_cnt_q [HIST_BINS];

    ////////////////////////////////////////////////////////////////////////////
    // clear and increment
    ////////////////////////////////////////////////////////////////////////////
    // registered counters, so back to back hits on one bin just chain
    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            for (int i = 0; i < HIST_BINS; i++) begin
                bin_cnt_q[i] <= '0;
            end
        end else if (inc_i) begin
            bin_cnt_q[inc_bin_i] <= bin_cnt_q[inc_bin_i] + 1'b1;
        end
    end

    // read is combinational
    assign rd_count_o = bin_cnt_q[rd_bin_i];

endmodule

// File: source/frame_buffer.sv
// frame pixel RAM

`timescale 1ns/1ps

module frame_buffer (
    input  logic                clk_i,
    input  image_pkg::buf_wr_t  wr_i,
    input  image_pkg::addr_t    rd_addr_i,
    output image_pkg::pixel_t   rd_data_o
);
    import image_pkg::*;

    pixel_t mem [FRAME_PIXELS];

    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // registered read, one cycle
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// File: source/block_placer.sv
// block to raster placer

`timescale 1ns/1ps

module block_placer (
    input  logic                clk_i,
    input  logic                rst_i,
    input  image_pkg::pix_in_t  pix_i,
    output image_pkg::buf_wr_t  wr_o,
    output logic                frame_done_o
);
    import image_pkg::*;

    logic [$clog2(BLK_DIM)-1:0]        col_in_blk;
    logic [$clog2(BLK_DIM)-1:0]        row_in_blk;
    logic [$clog2(BLKS_PER_ROW)-1:0]   blk_col;
    logic [$clog2(IMG_H/BLK_DIM)-1:0]  blk_row;
    logic [$clog2(IMG_H)-1:0]          pix_row;
    logic [$clog2(IMG_W)-1:0]          pix_col;
    logic                              blk_end;
    logic                              frame_end;
    addr_t                             wr_addr_d;

    logic   wr_en_q;
    addr_t  wr_addr_q;
    pixel_t wr_data_q;
    logic   frame_done_q;

    // block edge is a power of two, so the row and column just concatenate
    assign pix_row   = {blk_row, row_in_blk};
    assign pix_col   = {blk_col, col_in_blk};
    assign wr_addr_d = addr_t'(pix_row) * addr_t'(IMG_W) + addr_t'(pix_col);

    assign blk_end   = ({row_in_blk, col_in_blk} == 6'(BLK_PIXELS - 1));
    assign frame_end = blk_end && (blk_col == 6'(BLKS_PER_ROW - 1))
                     && (blk_row == 5'(IMG_H / BLK_DIM - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            col_in_blk   <= '0;
            row_in_blk   <= '0;
            blk_col      <= '0;
            blk_row      <= '0;
            wr_en_q      <= 1'b0;
            frame_done_q <= 1'b0;
        end else begin
            wr_en_q      <= pix_i.valid;
            frame_done_q <= pix_i.valid && frame_end;
            if (pix_i.valid) begin
                col_in_blk <= col_in_blk + 1'b1;  // wraps at 8
                if (col_in_blk == 3'(BLK_DIM - 1)) begin
                    row_in_blk <= row_in_blk + 1'b1;
                end
                if (blk_end) begin
                    if (blk_col == 6'(BLKS_PER_ROW - 1)) begin
                        blk_col <= '0;
                        blk_row <= frame_end ? '0 : blk_row + 1'b1;
                    end else begin
                        blk_col <= blk_col + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        wr_addr_q <= wr_addr_d;
        wr_data_q <= pix_i.data;
    end

    assign wr_o         = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};
    assign frame_done_o = frame_done_q;

endmodule

// File: source/task_engine.sv
// task engine

`timescale 1ns/1ps

module task_engine (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  image_pkg::task_cmd_t   cmd_i,
    input  logic                   frame_done_i,
    output image_pkg::addr_t       rd_addr_o,
    input  image_pkg::pixel_t      rd_data_i,
    output image_pkg::raster_out_t raster_o,
    output image_pkg::hist_out_t   hist_o,
    output logic                   done_o
);
    import image_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SCAN,
        ST_DRAIN,
        ST_DUMP,
        ST_DONE
    } engine_state_e;

    engine_state_e state_q;
    task_op_e      cmd_op;
    task_op_e      op_q;
    logic          op_known;
    logic          accept;
    logic          frame_ready_q;
    addr_t         scan_addr_q;
    logic          rd_vld_q;     // data stage valid
    pixel_t        dump_bin_q;
    count_t        bin_count;

    assign cmd_op   = task_op_e'(cmd_i.op);
    assign op_known = (cmd_op == OP_STREAM) || (cmd_op == OP_HISTOGRAM);
    assign accept   = cmd_i.start && op_known && frame_ready_q && (state_q == ST_IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // FSM and scan address
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= ST_IDLE;
            op_q        <= OP_STREAM;
            scan_addr_q <= '0;
            dump_bin_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        op_q    <= cmd_op;
                        state_q <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    if (scan_addr_q == addr_t'(FRAME_PIXELS - 1)) begin
                        scan_addr_q <= '0;
                        state_q     <= ST_DRAIN;
                    end else begin
                        scan_addr_q <= scan_addr_q + 1'b1;
                    end
                end
                ST_DRAIN: state_q <= (op_q == OP_HISTOGRAM) ? ST_DUMP : ST_DONE;  // last read lands
                ST_DUMP: begin
                    dump_bin_q <= dump_bin_q + 1'b1;
                    if (dump_bin_q == pixel_t'(HIST_BINS - 1)) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_vld_q      <= 1'b0;
            frame_ready_q <= 1'b0;
        end else begin
            rd_vld_q <= (state_q == ST_SCAN);
            if (frame_done_i) begin
                frame_ready_q <= 1'b1;
            end else if (state_q == ST_DONE) begin
                frame_ready_q <= 1'b0;  // one task per loaded frame
            end
        end
    end

    histogram_table u_hist (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .clear_i    (accept && (cmd_op == OP_HISTOGRAM)),
        .inc_i      (rd_vld_q && (op_q == OP_HISTOGRAM)),
        .inc_bin_i  (rd_data_i),
        .rd_bin_i   (dump_bin_q),
        .rd_count_o (bin_count)
    );

    assign rd_addr_o = scan_addr_q;
    assign raster_o  = '{valid: rd_vld_q && (op_q == OP_STREAM), data: rd_data_i};
    assign hist_o    = '{valid: state_q == ST_DUMP, bin: dump_bin_q, count: bin_count};
    assign done_o    = (state_q == ST_DONE);

endmodule

// File: source/block_image_top.sv
// block image top level

`timescale 1ns/1ps

module block_image_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  image_pkg::pix_in_t     pix_i,
    input  image_pkg::task_cmd_t   cmd_i,
    output image_pkg::raster_out_t raster_o,
    output image_pkg::hist_out_t   hist_o,
    output logic                   done_o
);
    import image_pkg::*;

    buf_wr_t frame_wr;
    logic    frame_done;
    addr_t   rd_addr;
    pixel_t  rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // block order to raster order
    ////////////////////////////////////////////////////////////////////////////
    block_placer u_placer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .pix_i        (pix_i),
        .wr_o         (frame_wr),
        .frame_done_o (frame_done)
    );

    frame_buffer u_frame (
        .clk_i     (clk_i),
        .wr_i      (frame_wr),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // task dispatch
    ////////////////////////////////////////////////////////////////////////////
    task_engine u_engine (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_i        (cmd_i),
        .frame_done_i (frame_done),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data),
        .raster_o     (raster_o),
        .hist_o       (hist_o),
        .done_o       (done_o)
    );

endmodule

// File: tb/block_image_props.sv
// block image port properties

`timescale 1ns/1ps

module block_image_props (
    input logic                   clk_i,
    input logic                   rst_i,
    input image_pkg::pix_in_t     pix_i,
    input image_pkg::raster_out_t raster_o,
    input image_pkg::hist_out_t   hist_o,
    input logic                   done_o,
    input image_pkg::buf_wr_t     wr_i
);
    import image_pkg::*;

    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // output ports
    ////////////////////////////////////////////////////////////////////////////
    one_output_active : assert property (
        @(posedge clk_i) disable iff (rst_i) !(raster_o.valid && hist_o.valid)
    ) else begin
        fail_count++;
        $error("raster and histogram outputs valid in the same cycle");
    end

    quiet_in_reset : assert property (
        @(posedge clk_i) rst_i |=> (!raster_o.valid && !hist_o.valid && !done_o && !wr_i.en)
    ) else begin
        fail_count++;
        $error("output or write active after a reset cycle");
    end

    // frame RAM write port
    write_in_frame : assert property (
        @(posedge clk_i) disable iff (rst_i) wr_i.en |-> (wr_i.addr < addr_t'(FRAME_PIXELS))
    ) else begin
        fail_count++;
        $error("write address beyond the frame");
    end

    no_pixels_during_task : assert property (
        @(posedge clk_i) disable iff (rst_i) (raster_o.valid || hist_o.valid) |-> !pix_i.valid
    ) else begin
        fail_count++;
        $error("pixel strobe while task output is active");
    end

endmodule

bind block_image_top block_image_props u_props (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pix_i    (pix_i),
    .raster_o (raster_o),
    .hist_o   (hist_o),
    .done_o   (done_o),
    .wr_i     (frame_wr)
);

// File: tb/tb_block_image_top.sv
// block image testbench

`timescale 1ns/1ps

module tb_block_image_top;
    import image_pkg::*;

    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] LFSR_SEED    = 32'h27aafd7d;
    localparam logic [31:0] LFSR_TAPS    = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
    // longest task from start to done, histogram scan plus bin dump
    localparam int TASK_CYCLES = FRAME_PIXELS + HIST_BINS + 20;
    // three frame loads, three tasks, two rejection windows, plus margin
    localparam int WATCHDOG_CYCLES = 3 * FRAME_PIXELS + 5 * TASK_CYCLES + 4000;

    logic        clk_i = 1'b0;
    logic        rst_i;
    pix_in_t     pix_i;
    task_cmd_t   cmd_i;
    raster_out_t raster_o;
    hist_out_t   hist_o;
    logic        done_o;

    logic [31:0] lfsr_state;
    logic [7:0]  frame_blk [FRAME_PIXELS];  // pixels as sent, block order
    logic [31:0] hist_q [$];
    int          raster_idx = 0;
    int          hist_idx = 0;
    int          done_count = 0;
    int          last_raster_beats = 0;
    int          last_hist_beats = 0;

    block_image_top u_dut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .pix_i    (pix_i),
        .cmd_i    (cmd_i),
        .raster_o (raster_o),
        .hist_o   (hist_o),
        .done_o   (done_o)
    );

    always #50 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function logic [7:0] next_pixel();
        logic [7:0] px;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
            px[i]      = lfsr_state[0];
        end
        return px;
    endfunction

    // raster index k back to its position in block order
    function automatic logic [7:0] expected_raster_pixel(input int k);
        int row;
        int col;
        int blk;
        int pos;
        row = k / IMG_W;
        col = k % IMG_W;
        blk = (row / BLK_DIM) * BLKS_PER_ROW + col / BLK_DIM;
        pos = (row % BLK_DIM) * BLK_DIM + col % BLK_DIM;
        return frame_blk[blk * BLK_PIXELS + pos];
    endfunction

    function automatic int expected_hist(input int bin);
        int hits;
        hits = 0;
        for (int n = 0; n < FRAME_PIXELS; n++) begin
            if (frame_blk[n] == 8'(bin)) begin
                hits++;
            end
        end
        return hits;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            stop_on_failure("value mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic load_frame(input bit fresh_data);
        for (int n = 0; n < FRAME_PIXELS; n++) begin
            if (fresh_data) begin
                frame_blk[n] = next_pixel();
            end
            @(posedge clk_i);
            #10;
            pix_i = '{valid: 1'b1, data: frame_blk[n]};
        end
        @(posedge clk_i);
        #10;
        pix_i = '0;
        idle_cycles(4);  // last write, frame_done, frame_ready
    endtask

    task automatic issue_start(input logic [15:0] op);
        @(posedge clk_i);
        #10;
        cmd_i = '{start: 1'b1, op: op};
        @(posedge clk_i);
        #10;
        cmd_i.start = 1'b0;
    endtask

    task automatic wait_for_done(input int dones_before);
        while (done_count == dones_before) begin
            @(posedge clk_i);
        end
        idle_cycles(8);
        check_value("done_o pulses", 32'(done_count), 32'(dones_before + 1));
    endtask

    // start must be ignored, watched long enough for a task to show itself
    task automatic expect_no_response(input int dones_before, input int wait_cycles);
        idle_cycles(wait_cycles);
        check_value("raster_o beats", 32'(raster_idx), 32'd0);
        check_value("hist_o beats", 32'(hist_idx), 32'd0);
        check_value("done_o pulses", 32'(done_count), 32'(dones_before));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitor, outputs sampled on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (rst_i) begin
            check_value("raster_o.valid", 32'(raster_o.valid), 32'd0);
            check_value("hist_o.valid", 32'(hist_o.valid), 32'd0);
            check_value("done_o", 32'(done_o), 32'd0);
        end else begin
            if (raster_o.valid) begin
                if (raster_idx >= FRAME_PIXELS) begin
                    stop_on_failure("stream task sent more pixels than one frame");
                end else begin
                    check_value("raster_o.data", 32'(raster_o.data),
                                32'(expected_raster_pixel(raster_idx)));
                    raster_idx++;
                end
            end
            if (hist_o.valid) begin
                if (hist_idx >= HIST_BINS) begin
                    stop_on_failure("histogram task sent more than 256 bins");
                end else begin
                    if (hist_idx == 0) begin
                        hist_q.delete();
                    end
                    check_value("hist_o.bin", 32'(hist_o.bin), 32'(hist_idx));
                    check_value("hist_o.count", hist_o.count, 32'(expected_hist(hist_idx)));
                    hist_q.push_back(hist_o.count);
                    hist_idx++;
                end
            end
            if (done_o) begin
                last_raster_beats = raster_idx;
                last_hist_beats   = hist_idx;
                raster_idx        = 0;
                hist_idx          = 0;
                done_count++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        stop_on_failure("timeout: the run did not finish within its cycle budget");
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int          dones;
        logic [31:0] hist_sum;
        rst_i      = 1'b1;
        pix_i      = '0;
        cmd_i      = '0;
        lfsr_state = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #10;
        rst_i = 1'b0;

        // no frame loaded yet
        dones = done_count;
        issue_start(OP_STREAM);
        expect_no_response(dones, 20);

        load_frame(1'b1);
        dones = done_count;
        issue_start(OP_STREAM);
        wait_for_done(dones);
        check_value("stream pixel count", 32'(last_raster_beats), 32'(FRAME_PIXELS));
        check_value("stream hist beats", 32'(last_hist_beats), 32'd0);

        dones = done_count;  // frame already consumed
        issue_start(OP_HISTOGRAM);
        expect_no_response(dones, TASK_CYCLES);

        load_frame(1'b0);  // same frame again
        dones = done_count;
        issue_start(OP_HISTOGRAM);
        wait_for_done(dones);
        check_value("histogram bin count", 32'(last_hist_beats), 32'(HIST_BINS));
        check_value("histogram raster beats", 32'(last_raster_beats), 32'd0);
        hist_sum = '0;
        foreach (hist_q[i]) begin
            hist_sum += hist_q[i];
        end
        check_value("histogram count sum", hist_sum, 32'(FRAME_PIXELS));

        // new data, unknown op first
        load_frame(1'b1);
        dones = done_count;
        issue_start(16'hA020);
        expect_no_response(dones, TASK_CYCLES);
        issue_start(OP_STREAM);
        wait_for_done(dones);
        check_value("stream pixel count", 32'(last_raster_beats), 32'(FRAME_PIXELS));

        if (u_dut.u_props.fail_count != 0) begin
            stop_on_failure("port properties failed during the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: block_image_top.f
source/image_pkg.sv
source/histogram_table.sv
source/frame_buffer.sv
source/block_placer.sv
source/task_engine.sv
source/block_image_top.sv
tb/block_image_props.sv
tb/tb_block_image_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_block_image_top \
    --Mdir obj_dir -o tb_block_image_top \
    -f block_image_top.f

./obj_dir/tb_block_image_top 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without passing"
    exit 1
fi
echo "simulation passed"
